// ==== src.f ====
+incdir+verification
logic/rs_pkg.sv
logic/rs_alloc_ctrl.sv
logic/rs_wakeup.sv
logic/rs_entry_array.sv
logic/rs_select.sv
logic/rs_alu.sv
verification/rs_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module rs_alu_tb -f src.f -o rs_alu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rs_alu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== verification/rs_ref_model.svh ====
`ifndef RS_REF_MODEL_SVH
`define RS_REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////
// Reference model of the station stepped once per rising edge
////////////////////////////////////////////////////////////////////////

typedef struct packed {
	rs_pkg::rs_payload_t payload;
	logic                rs_ok;	// Source 1 ready
	logic                rt_ok;	// Source 2 ready
} held_entry_t;

held_entry_t model_q[$];	// Front is the oldest

// Index of the oldest entry with both sources ready or -1
function automatic int pick_oldest_ready();
	for (int i = 0; i < model_q.size(); i++) begin
		if (model_q[i].rs_ok && model_q[i].rt_ok) begin
			return i;
		end
	end
	return -1;
endfunction

function automatic logic station_full();
	return model_q.size() == DEPTH;
endfunction

function automatic logic expect_issue_valid(input logic stall_in);
	return (pick_oldest_ready() >= 0) && !stall_in;
endfunction

task automatic advance_model(input logic alloc_in, input rs_pkg::rs_dispatch_t disp,
		input rs_pkg::cdb_t bus, input logic stall_in);
	int          pick;
	logic        was_full;
	held_entry_t e;
	pick     = stall_in ? -1 : pick_oldest_ready();	// Pick sees ready bits from before the edge
	was_full = station_full();
	for (int i = 0; i < model_q.size(); i++) begin
		e = model_q[i];
		if (bus.valid && bus.tag == e.payload.p_rs) e.rs_ok = 1'b1;
		if (bus.valid && bus.tag == e.payload.p_rt) e.rt_ok = 1'b1;
		model_q[i] = e;
	end
	if (pick >= 0) model_q.delete(pick);
	if (alloc_in && !was_full) begin
		e.payload = disp.payload;
		e.rs_ok   = disp.rs_rdy || !disp.rs_read || (bus.valid && bus.tag == disp.payload.p_rs);
		e.rt_ok   = disp.rt_rdy || !disp.rt_read || (bus.valid && bus.tag == disp.payload.p_rt);
		model_q.push_back(e);
	end
endtask

`endif

// ==== verification/rs_alu_tb.sv ====
module rs_alu_tb;

	localparam int DEPTH          = 8;
	localparam int HALF           = 10;	// Half clock period
	localparam int SEED           = 95656;
	localparam int RAND_CYCLES    = 2000;
	localparam int DRAIN_CYCLES   = 200;
	localparam int TIMEOUT_CYCLES = RAND_CYCLES + DRAIN_CYCLES + 300;

	logic                 clk;
	logic                 rst;
	logic                 alloc_en;
	rs_pkg::rs_dispatch_t dispatch;
	rs_pkg::cdb_t         cdb;
	logic                 stall;
	logic                 issue_valid;
	rs_pkg::rs_payload_t  issue;
	logic                 full;

	int cycles         = 0;
	int flag_errors    = 0;
	int payload_errors = 0;
	int other_errors   = 0;
	int issues_checked = 0;
	int full_seen      = 0;

	`include "rs_ref_model.svh"

	rs_alu #(.DEPTH(DEPTH)) u_dut (
		.clk(clk), .rst(rst), .alloc_en(alloc_en), .dispatch(dispatch), .cdb(cdb),
		.stall(stall), .issue_valid(issue_valid), .issue(issue), .full(full)
	);

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %b, expected %b", $time, what, actual, expected);
			flag_errors++;
		end
	endtask

	task automatic check_payload(input rs_pkg::rs_payload_t actual,
			input rs_pkg::rs_payload_t expected);
		if (actual !== expected) begin
			$display("Error at %0t: issue payload is %h, expected %h", $time, actual, expected);
			payload_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// Tags limited to 0..7 so that bus matches are frequent
	function automatic logic [rs_pkg::PREG_W-1:0] small_tag(input logic [2:0] low);
		logic [rs_pkg::PREG_W-1:0] t;
		t      = '0;
		t[2:0] = low;
		return t;
	endfunction

	function automatic rs_pkg::rs_dispatch_t random_dispatch();
		rs_pkg::rs_dispatch_t d;
		logic [31:0]          r;
		r                  = $urandom;
		d.payload.pc       = $urandom;
		d.payload.rob_id   = r[rs_pkg::ROB_W-1:0];
		d.payload.op       = rs_pkg::alu_op_e'({5'b00000, r[6:4]});
		d.payload.imm      = r[31:16];
		r                  = $urandom;
		d.payload.p_rs     = small_tag(r[2:0]);
		d.payload.p_rt     = small_tag(r[5:3]);
		d.payload.p_rd     = r[11:6];
		d.rs_rdy           = r[12] & r[13];	// About one in four
		d.rt_rdy           = r[14] & r[15];
		d.rs_read          = r[16] | r[17];
		d.rt_read          = r[18] | r[19];
		return d;
	endfunction

	// Drive at the falling edge, check just before the rising edge, then step the model
	task automatic run_cycle(input logic a, input rs_pkg::rs_dispatch_t d,
			input rs_pkg::cdb_t b, input logic s);
		int idx;
		@(negedge clk);
		alloc_en = a;
		dispatch = d;
		cdb      = b;
		stall    = s;
		#(HALF - 2);
		check_bit(full, station_full(), "full");
		check_bit(issue_valid, expect_issue_valid(s), "issue_valid");
		idx = pick_oldest_ready();
		if (expect_issue_valid(s) && issue_valid) begin
			check_payload(issue, model_q[idx].payload);
			issues_checked++;
		end
		if (full) full_seen++;
		advance_model(a, d, b, s);
	endtask

	initial begin
		logic [31:0]  r;
		rs_pkg::cdb_t b;
		void'($urandom(SEED));
		rst      = 1'b0;
		alloc_en = 1'b0;
		dispatch = '0;
		cdb      = '0;
		stall    = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		for (int i = 0; i < RAND_CYCLES; i++) begin
			r       = $urandom;
			b.valid = r[6];
			b.tag   = small_tag(r[10:8]);
			run_cycle(r[2:0] < 3'd5, random_dispatch(), b, r[5:4] == 2'b00);
		end

		// Drain with every small tag swept across the bus
		for (int i = 0; i < DRAIN_CYCLES; i++) begin
			b.valid = 1'b1;
			b.tag   = small_tag(3'(i));
			run_cycle(1'b0, random_dispatch(), b, 1'b0);
		end

		@(negedge clk);
		cdb = '0;
		#(HALF - 2);
		check_bit(full, 1'b0, "full after drain");
		check_bit(issue_valid, 1'b0, "issue_valid after drain");
		if (model_q.size() != 0) begin
			$display("Model still holds %0d entries after the drain phase", model_q.size());
			other_errors++;
		end
		if (full_seen == 0) begin
			$display("The random phase never filled the station");
			other_errors++;
		end

		$display("Errors: flags %0d, payload %0d, other %0d (issues checked %0d)",
			flag_errors, payload_errors, other_errors, issues_checked);
		if (flag_errors + payload_errors + other_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== logic/rs_alu.sv ====
module rs_alu #(
	parameter int DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 alloc_en,	// From decode
	input  rs_pkg::rs_dispatch_t dispatch,
	input  rs_pkg::cdb_t         cdb,
	input  logic                 stall,	// From execute
	output logic                 issue_valid,
	output rs_pkg::rs_payload_t  issue,
	output logic                 full	// To decode
);

	localparam int IDX_W = $clog2(DEPTH);

	logic                                  alloc_accept;
	logic [IDX_W-1:0]                      alloc_slot;
	logic                                  issue_fire;
	logic [IDX_W-1:0]                      issue_idx;
	logic [DEPTH-1:0]                      rs_hit;
	logic [DEPTH-1:0]                      rt_hit;
	logic                                  in_rs_hit;
	logic                                  in_rt_hit;
	logic [DEPTH-1:0]                      entry_valid;
	logic [DEPTH-1:0]                      entry_rs_rdy;
	logic [DEPTH-1:0]                      entry_rt_rdy;
	rs_pkg::rs_payload_t [DEPTH-1:0]       entry_payload;
	logic [DEPTH-1:0][rs_pkg::PREG_W-1:0]  entry_p_rs;
	logic [DEPTH-1:0][rs_pkg::PREG_W-1:0]  entry_p_rt;

	// Source tags of each held entry, for the CDB compare
	genvar g;
	generate
		for (g = 0; g < DEPTH; g++) begin : g_tags
			assign entry_p_rs[g] = entry_payload[g].p_rs;
			assign entry_p_rt[g] = entry_payload[g].p_rt;
		end
	endgenerate

	rs_alloc_ctrl #(.DEPTH(DEPTH)) u_alloc_ctrl (
		.clk(clk), .rst(rst), .alloc_en(alloc_en), .issue_fire(issue_fire),
		.alloc_accept(alloc_accept), .alloc_slot(alloc_slot), .full(full)
	);

	rs_wakeup #(.DEPTH(DEPTH)) u_wakeup (
		.cdb(cdb), .entry_p_rs(entry_p_rs), .entry_p_rt(entry_p_rt),
		.in_p_rs(dispatch.payload.p_rs), .in_p_rt(dispatch.payload.p_rt),
		.rs_hit(rs_hit), .rt_hit(rt_hit), .in_rs_hit(in_rs_hit), .in_rt_hit(in_rt_hit)
	);

	rs_entry_array #(.DEPTH(DEPTH)) u_entry_array (
		.clk(clk), .rst(rst), .alloc_accept(alloc_accept), .alloc_slot(alloc_slot),
		.dispatch(dispatch), .in_rs_hit(in_rs_hit), .in_rt_hit(in_rt_hit),
		.rs_hit(rs_hit), .rt_hit(rt_hit), .issue_fire(issue_fire), .issue_idx(issue_idx),
		.entry_valid(entry_valid), .entry_rs_rdy(entry_rs_rdy),
		.entry_rt_rdy(entry_rt_rdy), .entry_payload(entry_payload)
	);

	rs_select #(.DEPTH(DEPTH)) u_select (
		.entry_valid(entry_valid), .entry_rs_rdy(entry_rs_rdy),
		.entry_rt_rdy(entry_rt_rdy), .entry_payload(entry_payload), .stall(stall),
		.issue_fire(issue_fire), .issue_idx(issue_idx),
		.issue_valid(issue_valid), .issue(issue)
	);

endmodule

// ==== logic/rs_select.sv ====
module rs_select #(
	parameter int DEPTH = 8
) (
	input  logic [DEPTH-1:0]                    entry_valid,
	input  logic [DEPTH-1:0]                    entry_rs_rdy,
	input  logic [DEPTH-1:0]                    entry_rt_rdy,
	input  rs_pkg::rs_payload_t [DEPTH-1:0]     entry_payload,
	input  logic                                stall,
	output logic                                issue_fire,
	output logic [$clog2(DEPTH)-1:0]            issue_idx,
	output logic                                issue_valid,
	output rs_pkg::rs_payload_t                 issue
);

	localparam int IDX_W = $clog2(DEPTH);

	logic [DEPTH-1:0] inst_rdy;	// Valid with both operands ready
	logic             any_rdy;

	assign inst_rdy = entry_valid & entry_rs_rdy & entry_rt_rdy;
	assign any_rdy  = |inst_rdy;

	//////////////////////////////////////////////////////////////////////
	// Oldest ready wins
	//////////////////////////////////////////////////////////////////////

	// Scan from the top so the lowest ready index is the last one kept
	always_comb begin
		issue_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (inst_rdy[i]) begin
				issue_idx = IDX_W'(i);
			end
		end
	end

	assign issue_fire  = any_rdy && !stall;	// Stall holds everything
	assign issue_valid = issue_fire;
	assign issue       = entry_payload[issue_idx];

endmodule

// ==== logic/rs_entry_array.sv ====
module rs_entry_array #(
	parameter int DEPTH = 8
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                alloc_accept,
	input  logic [$clog2(DEPTH)-1:0]            alloc_slot,
	input  rs_pkg::rs_dispatch_t                dispatch,
	input  logic                                in_rs_hit,
	input  logic                                in_rt_hit,
	input  logic [DEPTH-1:0]                    rs_hit,
	input  logic [DEPTH-1:0]                    rt_hit,
	input  logic                                issue_fire,
	input  logic [$clog2(DEPTH)-1:0]            issue_idx,
	output logic [DEPTH-1:0]                    entry_valid,
	output logic [DEPTH-1:0]                    entry_rs_rdy,
	output logic [DEPTH-1:0]                    entry_rt_rdy,
	output rs_pkg::rs_payload_t [DEPTH-1:0]     entry_payload
);

	localparam int IDX_W = $clog2(DEPTH);

	logic in_rs_rdy;
	logic in_rt_rdy;

	// Ready at allocation when the PRF says so, when not read or when on the CDB now
	assign in_rs_rdy = dispatch.rs_rdy || !dispatch.rs_read || in_rs_hit;
	assign in_rt_rdy = dispatch.rt_rdy || !dispatch.rt_read || in_rt_hit;

	//////////////////////////////////////////////////////////////////////
	// Per-entry storage with index 0 as the oldest
	//////////////////////////////////////////////////////////////////////

	genvar g;
	generate
		for (g = 0; g < DEPTH; g++) begin : g_entry
			logic                wr;
			logic                shift;
			logic                up_valid;
			logic                up_rs_rdy;
			logic                up_rt_rdy;
			rs_pkg::rs_payload_t up_payload;
			logic                valid_r;
			logic                rs_rdy_r;
			logic                rt_rdy_r;
			rs_pkg::rs_payload_t payload_r;

			assign wr    = alloc_accept && (alloc_slot == IDX_W'(g));
			assign shift = issue_fire && (IDX_W'(g) >= issue_idx);	// Close the gap

			// Upper neighbour with its wakeup hit folded in
			if (g < DEPTH - 1) begin : g_upper
				assign up_valid   = entry_valid[g+1];
				assign up_rs_rdy  = entry_rs_rdy[g+1] | rs_hit[g+1];
				assign up_rt_rdy  = entry_rt_rdy[g+1] | rt_hit[g+1];
				assign up_payload = entry_payload[g+1];
			end else begin : g_top
				assign up_valid   = 1'b0;	// Nothing above the last slot
				assign up_rs_rdy  = 1'b0;
				assign up_rt_rdy  = 1'b0;
				assign up_payload = '0;
			end

			// Write wins over shift since an issue moves the slot to count-1
			always_ff @(posedge clk or negedge rst) begin
				if (!rst) begin
					valid_r  <= 1'b0;
					rs_rdy_r <= 1'b0;
					rt_rdy_r <= 1'b0;
				end else if (wr) begin
					valid_r  <= 1'b1;
					rs_rdy_r <= in_rs_rdy;
					rt_rdy_r <= in_rt_rdy;
				end else if (shift) begin
					valid_r  <= up_valid;
					rs_rdy_r <= up_rs_rdy;
					rt_rdy_r <= up_rt_rdy;
				end else begin
					rs_rdy_r <= rs_rdy_r | rs_hit[g];	// Wakeup in place
					rt_rdy_r <= rt_rdy_r | rt_hit[g];
				end
			end

			always_ff @(posedge clk) begin
				if (wr) begin
					payload_r <= dispatch.payload;
				end else if (shift) begin
					payload_r <= up_payload;
				end
			end

			assign entry_valid[g]   = valid_r;
			assign entry_rs_rdy[g]  = rs_rdy_r;
			assign entry_rt_rdy[g]  = rt_rdy_r;
			assign entry_payload[g] = payload_r;
		end
	endgenerate

endmodule

// ==== logic/rs_wakeup.sv ====
module rs_wakeup #(
	parameter int DEPTH = 8
) (
	input  rs_pkg::cdb_t                           cdb,
	input  logic [DEPTH-1:0][rs_pkg::PREG_W-1:0]   entry_p_rs,
	input  logic [DEPTH-1:0][rs_pkg::PREG_W-1:0]   entry_p_rt,
	input  logic [rs_pkg::PREG_W-1:0]              in_p_rs,
	input  logic [rs_pkg::PREG_W-1:0]              in_p_rt,
	output logic [DEPTH-1:0]                       rs_hit,
	output logic [DEPTH-1:0]                       rt_hit,
	output logic                                   in_rs_hit,
	output logic                                   in_rt_hit
);

	//////////////////////////////////////////////////////////////////////
	// Tag match against held entries
	//////////////////////////////////////////////////////////////////////

	// Hits are by position in the array as it stands this cycle.
	// Invalid slots may match; their ready bits are never looked at.
	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			rs_hit[i] = cdb.valid && (cdb.tag == entry_p_rs[i]);
			rt_hit[i] = cdb.valid && (cdb.tag == entry_p_rt[i]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Forwarding to the allocation in flight
	//////////////////////////////////////////////////////////////////////

	assign in_rs_hit = cdb.valid && (cdb.tag == in_p_rs);
	assign in_rt_hit = cdb.valid && (cdb.tag == in_p_rt);

endmodule

// ==== logic/rs_alloc_ctrl.sv ====
module rs_alloc_ctrl #(
	parameter int DEPTH = 8
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     alloc_en,
	input  logic                     issue_fire,
	output logic                     alloc_accept,
	output logic [$clog2(DEPTH)-1:0] alloc_slot,
	output logic                     full
);

	localparam int IDX_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [CNT_W-1:0] count;	// Held entries, also the first free slot
	logic [CNT_W-1:0] slot_wide;

	assign full         = (count == CNT_W'(DEPTH));
	assign alloc_accept = alloc_en && !full;	// Dropped while full

	// Array closes up by one when an issue happens in the same cycle
	assign slot_wide  = issue_fire ? count - 1'b1 : count;
	assign alloc_slot = slot_wide[IDX_W-1:0];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count <= '0;
		end else begin
			case ({alloc_accept, issue_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Idle, or one in and one out
			endcase
		end
	end

endmodule

// ==== logic/rs_pkg.sv ====
package rs_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int PREG_W = 6;	// Physical register tag
	localparam int ROB_W  = 4;	// Reorder buffer index
	localparam int PC_W   = 32;
	localparam int IMM_W  = 16;

	// Execute control codes, carried through the station untouched
	typedef enum logic [7:0] {
		ALU_ADD = 8'h00,
		ALU_SUB = 8'h01,
		ALU_AND = 8'h02,
		ALU_OR  = 8'h03,
		ALU_XOR = 8'h04,
		ALU_SLT = 8'h05,
		ALU_SLL = 8'h06,
		ALU_SRL = 8'h07
	} alu_op_e;

	//////////////////////////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [PC_W-1:0]   pc;
		logic [ROB_W-1:0]  rob_id;
		alu_op_e           op;
		logic [IMM_W-1:0]  imm;
		logic [PREG_W-1:0] p_rs;	// Source 1 tag
		logic [PREG_W-1:0] p_rt;	// Source 2 tag
		logic [PREG_W-1:0] p_rd;	// Destination, becomes the CDB tag
	} rs_payload_t;

	typedef struct packed {
		rs_payload_t payload;
		logic        rs_rdy;	// From PRF valid array
		logic        rt_rdy;
		logic        rs_read;	// Operand used at all
		logic        rt_read;
	} rs_dispatch_t;

	typedef struct packed {
		logic              valid;
		logic [PREG_W-1:0] tag;
	} cdb_t;

endpackage
